//--- files.f
verilog/missProcPkg.sv
verilog/vacancyClaim.sv
verilog/missLookup.sv
verilog/missRoute.sv
verilog/missProcTop.sv
sim/missProc_properties.sv
sim/missProcTb.sv

//--- run.sh
#!/bin/sh
# Build and run the miss processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module missProcTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/VmissProcTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
   exit 0
else
   exit 1
fi

//--- sim/missProcTb.sv
// Directed testbench for the miss processing pipeline
// Plays the tracker and pending queue, checks routing two cycles after each put

`timescale 1ns/10ps
`default_nettype none

module missProcTb;

   localparam int MissTrkDepth = 8;
   localparam int PendQDepth   = 8;
   localparam int TrkIdxWidth  = $clog2(MissTrkDepth);
   localparam int PqIdxWidth   = $clog2(PendQDepth);
   localparam int AddrWidth    = missProcPkg::AddrWidth;
   localparam int TlbIdWidth   = missProcPkg::TlbIdWidth;
   localparam int ClkPeriod    = 8;
   localparam int SingleReqs   = 20;                    // Requests through sendAndCheck
   localparam int TestCycles   = SingleReqs * 3 + 40;   // Plus pipelined tests and idles
   localparam int MarginCycles = 50;

   logic                     clk;
   logic                     reset_i;
   logic                     msProcPut;
   missProcPkg::opcode_e     msProcOpcode;
   logic [AddrWidth-1:0]     msProcAddr;
   logic [TlbIdWidth-1:0]    msProcTlbId;
   logic                     msTrkCamEn;
   missProcPkg::opcode_e     msTrkCamOpcode;
   logic [AddrWidth-1:0]     msTrkCamAddr;
   logic [TlbIdWidth-1:0]    msTrkCamTlbId;
   logic [MissTrkDepth-1:0]  msTrkCamHit;
   logic [MissTrkDepth-1:0]  msTrkVld;
   logic [MissTrkDepth-1:0]  msTrkWrOp;
   logic [MissTrkDepth-1:0]  msTrkVacant;
   logic                     msTrkReqPut;
   logic [TrkIdxWidth-1:0]   msTrkReqIdx;
   missProcPkg::opcode_e     msTrkReqOpcode;
   logic [AddrWidth-1:0]     msTrkReqAddr;
   logic [TlbIdWidth-1:0]    msTrkReqTlbId;
   logic                     pendQFull;
   logic [PendQDepth-1:0]    pendQVacant;
   logic                     pendQPut;
   logic [PqIdxWidth-1:0]    pendQIdx;
   logic [TrkIdxWidth-1:0]   pendQMsHitIdx;
   logic                     primCrdRet;
   logic                     pendQCrdRet;

   // Round-robin reference pointers
   int trkPtr     = 0;
   int pqPtr      = 0;
   int lastTrkIdx = 0;
   int checks     = 0;
   int errors     = 0;

   missProcTop #(
      .MissTrkDepth (MissTrkDepth),
      .PendQDepth   (PendQDepth)
   ) dut_i (
      .clk              (clk),
      .reset_i          (reset_i),
      .msProcPut_i      (msProcPut),
      .msProcOpcode_i   (msProcOpcode),
      .msProcAddr_i     (msProcAddr),
      .msProcTlbId_i    (msProcTlbId),
      .msTrkCamEn_o     (msTrkCamEn),
      .msTrkCamOpcode_o (msTrkCamOpcode),
      .msTrkCamAddr_o   (msTrkCamAddr),
      .msTrkCamTlbId_o  (msTrkCamTlbId),
      .msTrkCamHit_i    (msTrkCamHit),
      .msTrkVld_i       (msTrkVld),
      .msTrkWrOp_i      (msTrkWrOp),
      .msTrkVacant_i    (msTrkVacant),
      .msTrkReqPut_o    (msTrkReqPut),
      .msTrkReqIdx_o    (msTrkReqIdx),
      .msTrkReqOpcode_o (msTrkReqOpcode),
      .msTrkReqAddr_o   (msTrkReqAddr),
      .msTrkReqTlbId_o  (msTrkReqTlbId),
      .pendQFull_i      (pendQFull),
      .pendQVacant_i    (pendQVacant),
      .pendQPut_o       (pendQPut),
      .pendQIdx_o       (pendQIdx),
      .pendQMsHitIdx_o  (pendQMsHitIdx),
      .primCrdRet_o     (primCrdRet),
      .pendQCrdRet_o    (pendQCrdRet)
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   //--------------------------------------------------
   // Helpers
   //--------------------------------------------------
   task automatic tick();
      @(posedge clk);
      #1;                                               // Drive after the edge
   endtask

   function automatic logic [AddrWidth-1:0] randAddr();
      return AddrWidth'($urandom());
   endfunction

   // First vacant entry at or after ptr, wrapping
   function automatic int firstVacant(input logic [31:0] vacant, input int ptr,
                                      input int depth);
      int idx;

      for (int i = 0; i < depth; i++) begin
         idx = (ptr + i) % depth;
         if (vacant[idx]) begin
            return idx;
         end
      end
      return 0;
   endfunction

   task automatic checkVal(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic putReq(input missProcPkg::opcode_e op, input logic [AddrWidth-1:0] addr,
                         input logic [TlbIdWidth-1:0] tlbId);
      msProcPut    = 1'b1;
      msProcOpcode = op;
      msProcAddr   = addr;
      msProcTlbId  = tlbId;
   endtask

   // Checks the out stage in the current cycle, then moves the reference pointers
   task automatic checkOut(input bit toPendQ, input missProcPkg::opcode_e op,
                           input logic [AddrWidth-1:0] addr,
                           input logic [TlbIdWidth-1:0] tlbId, input int hitIdx);
      int expIdx;

      @(negedge clk);
      checkVal("msTrkReqOpcode_o", 32'(msTrkReqOpcode), 32'(op));
      checkVal("msTrkReqAddr_o", 32'(msTrkReqAddr), 32'(addr));
      checkVal("msTrkReqTlbId_o", 32'(msTrkReqTlbId), 32'(tlbId));
      if (toPendQ) begin
         expIdx = firstVacant(32'(pendQVacant), pqPtr, PendQDepth);
         checkVal("pendQPut_o", 32'(pendQPut), 1);
         checkVal("msTrkReqPut_o", 32'(msTrkReqPut), 0);
         checkVal("pendQIdx_o", 32'(pendQIdx), expIdx);
         checkVal("pendQMsHitIdx_o", 32'(pendQMsHitIdx), hitIdx);
         checkVal("primCrdRet_o", 32'(primCrdRet), 1);
         checkVal("pendQCrdRet_o", 32'(pendQCrdRet), 0);
         pqPtr = (expIdx + 1) % PendQDepth;
      end else begin
         expIdx = firstVacant(32'(msTrkVacant), trkPtr, MissTrkDepth);
         checkVal("msTrkReqPut_o", 32'(msTrkReqPut), 1);
         checkVal("pendQPut_o", 32'(pendQPut), 0);
         checkVal("msTrkReqIdx_o", 32'(msTrkReqIdx), expIdx);
         checkVal("pendQCrdRet_o", 32'(pendQCrdRet), 1);
         checkVal("primCrdRet_o", 32'(primCrdRet), 0);
         trkPtr     = (expIdx + 1) % MissTrkDepth;
         lastTrkIdx = expIdx;
      end
   endtask

   // One request alone in the pipe, CAM answers the cycle after the lookup
   task automatic sendAndCheck(input missProcPkg::opcode_e op,
                               input logic [AddrWidth-1:0] addr,
                               input logic [TlbIdWidth-1:0] tlbId,
                               input logic [MissTrkDepth-1:0] camHit,
                               input bit toPendQ, input int hitIdx);
      tick();
      putReq(op, addr, tlbId);
      @(negedge clk);
      checkVal("msTrkCamEn_o", 32'(msTrkCamEn), 1);
      checkVal("msTrkCamOpcode_o", 32'(msTrkCamOpcode), 32'(op));
      checkVal("msTrkCamAddr_o", 32'(msTrkCamAddr), 32'(addr));
      checkVal("msTrkCamTlbId_o", 32'(msTrkCamTlbId), 32'(tlbId));
      tick();
      msProcPut   = 1'b0;
      msTrkCamHit = camHit;
      tick();
      msTrkCamHit = '0;
      checkOut(toPendQ, op, addr, tlbId, hitIdx);
   endtask

   //--------------------------------------------------
   // Directed tests
   //--------------------------------------------------
   task automatic missAllocTest();
      for (int n = 0; n < 3; n++) begin
         sendAndCheck((n % 2 == 0) ? missProcPkg::OpTrnRd : missProcPkg::OpTrnWr,
                      randAddr(), 2'(n), '0, 1'b0, 0);
      end
   endtask

   task automatic qualHitTest();
      sendAndCheck(missProcPkg::OpTrnRd, randAddr(), 2'd1, 8'b0010_0100, 1'b1, 2);
      tick();
      msTrkWrOp = 8'b0100_0000;                         // Only entry 6 is a write
      sendAndCheck(missProcPkg::OpTrnWr, randAddr(), 2'd1, 8'b0100_0010, 1'b1, 6);
      sendAndCheck(missProcPkg::OpTrnWr, randAddr(), 2'd2, 8'b0000_0011, 1'b0, 0);
      tick();
      msTrkVld = 8'b1111_0111;                          // Hit on a retired entry
      sendAndCheck(missProcPkg::OpTrnRd, randAddr(), 2'd0, 8'b0000_1000, 1'b0, 0);
      tick();
      msTrkVld  = '1;
      msTrkWrOp = '0;
   endtask

   task automatic fullPendQTest();
      tick();
      pendQFull = 1'b1;
      sendAndCheck(missProcPkg::OpTrnRd, randAddr(), 2'd0, 8'b0001_0000, 1'b0, 0);
      tick();
      pendQFull = 1'b0;
   endtask

   // Second request one, then two, cycles behind a tracker-bound one
   task automatic aheadMatchTest();
      logic [AddrWidth-1:0] addr;

      for (int gap = 1; gap <= 2; gap++) begin
         addr = randAddr();
         tick();
         putReq(missProcPkg::OpTrnWr, addr, 2'd3);
         tick();
         if (gap == 1) begin
            putReq(missProcPkg::OpTrnRd, addr, 2'd3);
         end else begin
            msProcPut = 1'b0;
         end
         tick();
         if (gap == 2) begin
            putReq(missProcPkg::OpTrnRd, addr, 2'd3);
         end else begin
            msProcPut = 1'b0;
         end
         checkOut(1'b0, missProcPkg::OpTrnWr, addr, 2'd3, 0);
         tick();
         msProcPut = 1'b0;
         if (gap == 2) begin
            tick();
         end
         checkOut(1'b1, missProcPkg::OpTrnRd, addr, 2'd3, lastTrkIdx);
      end
   endtask

   task automatic conflictMaskTest();
      logic [AddrWidth-1:0] addrA;
      logic [AddrWidth-1:0] addrC;
      int                   conflictIdx;

      addrA = randAddr();
      addrC = ~addrA;                                   // Different page
      tick();
      putReq(missProcPkg::OpTrnRd, addrA, 2'd0);
      tick();
      msProcPut = 1'b0;
      tick();
      putReq(missProcPkg::OpTrnRd, addrC, 2'd0);        // Lookup while A is written
      checkOut(1'b0, missProcPkg::OpTrnRd, addrA, 2'd0, 0);
      conflictIdx = lastTrkIdx;
      tick();
      msProcPut   = 1'b0;
      msTrkCamHit = MissTrkDepth'(1) << conflictIdx;
      tick();
      msTrkCamHit = '0;
      checkOut(1'b0, missProcPkg::OpTrnRd, addrC, 2'd0, 0);
   endtask

   task automatic roundRobinTest();
      tick();
      msTrkVacant = 8'b1010_0100;
      pendQVacant = 8'b0100_1001;
      for (int n = 0; n < 4; n++) begin
         sendAndCheck(missProcPkg::OpTrnRd, randAddr(), 2'd1, '0, 1'b0, 0);
      end
      for (int n = 0; n < 4; n++) begin
         sendAndCheck(missProcPkg::OpTrnRd, randAddr(), 2'd1, 8'h80, 1'b1, 7);
      end
      // Interleaved, each queue keeps its own pointer
      for (int n = 0; n < 4; n++) begin
         sendAndCheck(missProcPkg::OpTrnRd, randAddr(), 2'd2,
                      (n % 2 == 1) ? 8'h80 : 8'h00, 1'(n % 2), 7);
      end
      tick();
      msTrkVacant = '1;
      pendQVacant = '1;
   endtask

   //--------------------------------------------------
   // Main sequence and watchdog
   //--------------------------------------------------
   initial begin
      int assertFails;

      void'($urandom(17701));
      reset_i      = 1'b1;
      msProcPut    = 1'b0;
      msProcOpcode = missProcPkg::OpTrnRd;
      msProcAddr   = '0;
      msProcTlbId  = '0;
      msTrkCamHit  = '0;
      msTrkVld     = '1;
      msTrkWrOp    = '0;
      msTrkVacant  = '1;
      pendQFull    = 1'b0;
      pendQVacant  = '1;
      repeat (2) @(posedge clk);
      #1;
      reset_i = 1'b0;

      missAllocTest();
      qualHitTest();
      fullPendQTest();
      aheadMatchTest();
      conflictMaskTest();
      roundRobinTest();
      tick();
      tick();

      assertFails = dut_i.props_i.failCount;
      $display("Checks: %0d, errors: %0d, property failures: %0d",
               checks, errors, assertFails);
      if (errors == 0 && assertFails == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      #((TestCycles + MarginCycles) * ClkPeriod);
      $display("Timeout: tests still running after %0d cycles", TestCycles + MarginCycles);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/missProc_properties.sv
// Concurrent checks on the miss processing top level ports
// Attached to every missProcTop instance

`timescale 1ns/10ps
`default_nettype none

module missProc_properties #(
   parameter int PendQDepth = 8,
   localparam int PqIdxWidth = $clog2(PendQDepth)
) (
   input wire logic                  clk,
   input wire logic                  reset_i,
   input wire logic                  msProcPut_i,
   input wire logic                  msTrkCamEn_o,
   input wire logic                  msTrkReqPut_o,
   input wire logic                  pendQPut_o,
   input wire logic [PqIdxWidth-1:0] pendQIdx_o,
   input wire logic [PendQDepth-1:0] pendQVacant_i
);

   int failCount = 0;                               // Property failures so far

   //--------------------------------------------------
   // Port rules
   //--------------------------------------------------
   camEnFollowsPut: assert property (@(posedge clk) disable iff (reset_i)
      msTrkCamEn_o == msProcPut_i)
      else begin
         failCount++;
         $error("CAM enable differs from request put");
      end

   singlePut: assert property (@(posedge clk) disable iff (reset_i)
      !(msTrkReqPut_o && pendQPut_o))
      else begin
         failCount++;
         $error("Tracker and pending queue put in the same cycle");
      end

   // Two stages from put to exactly one destination
   putRouted: assert property (@(posedge clk) disable iff (reset_i)
      msProcPut_i |-> ##2 (msTrkReqPut_o ^ pendQPut_o))
      else begin
         failCount++;
         $error("Request not routed to exactly one queue two cycles after put");
      end

   pendQTargetVacant: assert property (@(posedge clk) disable iff (reset_i)
      pendQPut_o |-> pendQVacant_i[pendQIdx_o])
      else begin
         failCount++;
         $error("Pending queue put to an occupied entry");
      end

endmodule

bind missProcTop missProc_properties #(.PendQDepth(PendQDepth)) props_i (
   .clk           (clk),
   .reset_i       (reset_i),
   .msProcPut_i   (msProcPut_i),
   .msTrkCamEn_o  (msTrkCamEn_o),
   .msTrkReqPut_o (msTrkReqPut_o),
   .pendQPut_o    (pendQPut_o),
   .pendQIdx_o    (pendQIdx_o),
   .pendQVacant_i (pendQVacant_i)
);

`default_nettype wire

//--- verilog/missLookup.sv
// Miss lookup, CAM control and CAM return stages
// Qualifies tracker CAM hits and matches against the request ahead

`timescale 1ns/10ps
`default_nettype none

module missLookup #(
   parameter int MissTrkDepth = 8,
   localparam int TrkIdxWidth = $clog2(MissTrkDepth),
   localparam int AddrWidth   = missProcPkg::AddrWidth,
   localparam int TlbIdWidth  = missProcPkg::TlbIdWidth
) (
   input  wire logic                    clk,
   input  wire logic                    reset_i,
   // Incoming miss
   input  wire logic                    put_i,
   input  missProcPkg::opcode_e         opcode_i,
   input  wire logic [AddrWidth-1:0]    addr_i,
   input  wire logic [TlbIdWidth-1:0]   tlbId_i,
   // Tracker CAM and status
   output logic                         camEn_o,
   input  wire logic [MissTrkDepth-1:0] camHit_i,
   input  wire logic [MissTrkDepth-1:0] trkVld_i,
   input  wire logic [MissTrkDepth-1:0] trkWrOp_i,
   // Out stage state
   input  wire logic                    outVld_i,
   input  missProcPkg::opcode_e         outOpcode_i,
   input  wire logic [AddrWidth-1:0]    outAddr_i,
   input  wire logic [TlbIdWidth-1:0]   outTlbId_i,
   input  wire logic                    outTrkPut_i,
   input  wire logic [TrkIdxWidth-1:0]  outTrkIdx_i,
   input  wire logic [TrkIdxWidth-1:0]  outHitIdx_i,
   input  wire logic                    outHitVld_i,
   // CAM return results
   output logic                         retVld_o,
   output missProcPkg::opcode_e         retOpcode_o,
   output logic      [AddrWidth-1:0]    retAddr_o,
   output logic      [TlbIdWidth-1:0]   retTlbId_o,
   output logic                         retHitVld_o,
   output logic      [TrkIdxWidth-1:0]  retHitIdx_o
);

   // Where the out request lands, and whether that entry still holds
   logic                     aheadHitVld;
   logic [TrkIdxWidth-1:0]   aheadHitIdx;
   logic                     ctlHitVld;

   logic                     retVld;
   missProcPkg::opcode_e     retOpcode;
   logic [AddrWidth-1:0]     retAddr;
   logic [TlbIdWidth-1:0]    retTlbId;
   logic                     savedHitVld;
   logic [TrkIdxWidth-1:0]   savedHitIdx;
   logic                     confPut;               // Tracker write during lookup
   logic [TrkIdxWidth-1:0]   confIdx;

   logic [MissTrkDepth-1:0]  camHitVec;
   logic                     camHitVld;
   logic [TrkIdxWidth-1:0]   camHitIdx;

   assign aheadHitIdx = outTrkPut_i ? outTrkIdx_i : outHitIdx_i;
   assign aheadHitVld = outTrkPut_i || (outHitVld_i && trkVld_i[outHitIdx_i]);

   //--------------------------------------------------
   // CAM control stage
   //--------------------------------------------------
   assign camEn_o = put_i;

   assign ctlHitVld = outVld_i && aheadHitVld &&
                      missProcPkg::reqMatch(opcode_i, addr_i, tlbId_i,
                                            outOpcode_i, outAddr_i, outTlbId_i);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         retVld      <= 1'b0;
         savedHitVld <= 1'b0;
         confPut     <= 1'b0;
      end else begin
         retVld      <= put_i;
         savedHitVld <= put_i && ctlHitVld;
         confPut     <= put_i && outTrkPut_i;
      end
   end

   always_ff @(posedge clk) begin
      retOpcode   <= opcode_i;
      retAddr     <= addr_i;
      retTlbId    <= tlbId_i;
      savedHitIdx <= aheadHitIdx;
      confIdx     <= outTrkIdx_i;
   end

   //--------------------------------------------------
   // CAM return stage
   //--------------------------------------------------
   always_comb begin
      for (int i = 0; i < MissTrkDepth; i++) begin
         camHitVec[i] = camHit_i[i] && trkVld_i[i] &&
                        !(confPut && (confIdx == TrkIdxWidth'(i))) &&
                        ((retOpcode == missProcPkg::OpTrnRd) || trkWrOp_i[i]);
      end
      camHitVld = |camHitVec;
      // Several hits are legal, lowest one wins
      camHitIdx = '0;
      for (int i = MissTrkDepth - 1; i >= 0; i--) begin
         if (camHitVec[i]) begin
            camHitIdx = TrkIdxWidth'(i);
         end
      end
   end

   always_comb begin
      if (camHitVld) begin
         retHitVld_o = 1'b1;
         retHitIdx_o = camHitIdx;
      end else if (outVld_i &&
                   missProcPkg::reqMatch(retOpcode, retAddr, retTlbId,
                                         outOpcode_i, outAddr_i, outTlbId_i)) begin
         retHitVld_o = aheadHitVld;                 // Request just ahead
         retHitIdx_o = aheadHitIdx;
      end else begin
         // Match from control stage, entry may have retired since
         retHitVld_o = savedHitVld && trkVld_i[savedHitIdx];
         retHitIdx_o = savedHitIdx;
      end
   end

   assign retVld_o    = retVld;
   assign retOpcode_o = retOpcode;
   assign retAddr_o   = retAddr;
   assign retTlbId_o  = retTlbId;

endmodule

`default_nettype wire

//--- verilog/missProcPkg.sv
// Miss processing shared definitions
// Request field widths, translation opcode and the request match rule

`default_nettype none

package missProcPkg;

   //--------------------------------------------------
   // Request fields
   //--------------------------------------------------
   localparam int AddrWidth  = 20;                  // Page address bits
   localparam int TlbIdWidth = 2;

   typedef enum logic [0:0] {
      OpTrnRd = 1'b0,                               // Read translation
      OpTrnWr = 1'b1                                // Write translation
   } opcode_e;

   //--------------------------------------------------
   // Request match
   //--------------------------------------------------
   // A newer request may wait behind an older one when both target the same
   // page of the same TLB, and the older one grants at least the newer one's
   // permission
   function automatic logic reqMatch(
      input opcode_e               newOpcode,
      input logic [AddrWidth-1:0]  newAddr,
      input logic [TlbIdWidth-1:0] newTlbId,
      input opcode_e               oldOpcode,
      input logic [AddrWidth-1:0]  oldAddr,
      input logic [TlbIdWidth-1:0] oldTlbId
   );
      logic addrHit;
      logic tlbIdHit;
      logic opcodeHit;

      addrHit   = (newAddr == oldAddr);
      tlbIdHit  = (newTlbId == oldTlbId);
      opcodeHit = (newOpcode == OpTrnRd) || (oldOpcode == OpTrnWr);
      return addrHit && tlbIdHit && opcodeHit;
   endfunction

endpackage

`default_nettype wire

//--- verilog/missProcTop.sv
// Device TLB miss processing pipeline
// Lookup against the miss tracker, then park or allocate each miss

`timescale 1ns/10ps
`default_nettype none

module missProcTop #(
   parameter int MissTrkDepth = 8,
   parameter int PendQDepth   = 8,
   localparam int TrkIdxWidth = $clog2(MissTrkDepth),
   localparam int PqIdxWidth  = $clog2(PendQDepth),
   localparam int AddrWidth   = missProcPkg::AddrWidth,
   localparam int TlbIdWidth  = missProcPkg::TlbIdWidth
) (
   input  wire logic                    clk,
   input  wire logic                    reset_i,
   // Requester
   input  wire logic                    msProcPut_i,
   input  missProcPkg::opcode_e         msProcOpcode_i,
   input  wire logic [AddrWidth-1:0]    msProcAddr_i,
   input  wire logic [TlbIdWidth-1:0]   msProcTlbId_i,
   // Miss tracker CAM
   output logic                         msTrkCamEn_o,
   output missProcPkg::opcode_e         msTrkCamOpcode_o,
   output logic      [AddrWidth-1:0]    msTrkCamAddr_o,
   output logic      [TlbIdWidth-1:0]   msTrkCamTlbId_o,
   input  wire logic [MissTrkDepth-1:0] msTrkCamHit_i,
   input  wire logic [MissTrkDepth-1:0] msTrkVld_i,
   input  wire logic [MissTrkDepth-1:0] msTrkWrOp_i,
   input  wire logic [MissTrkDepth-1:0] msTrkVacant_i,
   // Miss tracker put
   output logic                         msTrkReqPut_o,
   output logic      [TrkIdxWidth-1:0]  msTrkReqIdx_o,
   output missProcPkg::opcode_e         msTrkReqOpcode_o,
   output logic      [AddrWidth-1:0]    msTrkReqAddr_o,
   output logic      [TlbIdWidth-1:0]   msTrkReqTlbId_o,
   // Pending queue, request fields shared with tracker put
   input  wire logic                    pendQFull_i,
   input  wire logic [PendQDepth-1:0]   pendQVacant_i,
   output logic                         pendQPut_o,
   output logic      [PqIdxWidth-1:0]   pendQIdx_o,
   output logic      [TrkIdxWidth-1:0]  pendQMsHitIdx_o,
   // Credits
   output logic                         primCrdRet_o,
   output logic                         pendQCrdRet_o
);

   //--------------------------------------------------
   // Stage to stage signals
   //--------------------------------------------------
   logic                    retVld;
   missProcPkg::opcode_e    retOpcode;
   logic [AddrWidth-1:0]    retAddr;
   logic [TlbIdWidth-1:0]   retTlbId;
   logic                    retHitVld;
   logic [TrkIdxWidth-1:0]  retHitIdx;

   logic                    outVld;
   logic                    outTrkPut;
   logic [TrkIdxWidth-1:0]  outTrkIdx;
   logic [TrkIdxWidth-1:0]  outHitIdx;
   logic                    outHitVld;

   // CAM key is the incoming request
   assign msTrkCamOpcode_o = msProcOpcode_i;
   assign msTrkCamAddr_o   = msProcAddr_i;
   assign msTrkCamTlbId_o  = msProcTlbId_i;

   missLookup #(.MissTrkDepth(MissTrkDepth)) lookup_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .put_i       (msProcPut_i),
      .opcode_i    (msProcOpcode_i),
      .addr_i      (msProcAddr_i),
      .tlbId_i     (msProcTlbId_i),
      .camEn_o     (msTrkCamEn_o),
      .camHit_i    (msTrkCamHit_i),
      .trkVld_i    (msTrkVld_i),
      .trkWrOp_i   (msTrkWrOp_i),
      .outVld_i    (outVld),
      .outOpcode_i (msTrkReqOpcode_o),
      .outAddr_i   (msTrkReqAddr_o),
      .outTlbId_i  (msTrkReqTlbId_o),
      .outTrkPut_i (outTrkPut),
      .outTrkIdx_i (outTrkIdx),
      .outHitIdx_i (outHitIdx),
      .outHitVld_i (outHitVld),
      .retVld_o    (retVld),
      .retOpcode_o (retOpcode),
      .retAddr_o   (retAddr),
      .retTlbId_o  (retTlbId),
      .retHitVld_o (retHitVld),
      .retHitIdx_o (retHitIdx)
   );

   missRoute #(
      .MissTrkDepth (MissTrkDepth),
      .PendQDepth   (PendQDepth)
   ) route_i (
      .clk             (clk),
      .reset_i         (reset_i),
      .retVld_i        (retVld),
      .retOpcode_i     (retOpcode),
      .retAddr_i       (retAddr),
      .retTlbId_i      (retTlbId),
      .retHitVld_i     (retHitVld),
      .retHitIdx_i     (retHitIdx),
      .pendQFull_i     (pendQFull_i),
      .trkVacant_i     (msTrkVacant_i),
      .pendQVacant_i   (pendQVacant_i),
      .outVld_o        (outVld),
      .outOpcode_o     (msTrkReqOpcode_o),
      .outAddr_o       (msTrkReqAddr_o),
      .outTlbId_o      (msTrkReqTlbId_o),
      .outTrkPut_o     (outTrkPut),
      .outTrkIdx_o     (outTrkIdx),
      .outHitIdx_o     (outHitIdx),
      .outHitVld_o     (outHitVld),
      .trkPut_o        (msTrkReqPut_o),
      .trkIdx_o        (msTrkReqIdx_o),
      .pendQPut_o      (pendQPut_o),
      .pendQIdx_o      (pendQIdx_o),
      .pendQMsHitIdx_o (pendQMsHitIdx_o),
      .primCrdRet_o    (primCrdRet_o),
      .pendQCrdRet_o   (pendQCrdRet_o)
   );

endmodule

`default_nettype wire

//--- verilog/missRoute.sv
// Miss route, out stage
// Sends each request to the pending queue or a new tracker entry

`timescale 1ns/10ps
`default_nettype none

module missRoute #(
   parameter int MissTrkDepth = 8,
   parameter int PendQDepth   = 8,
   localparam int TrkIdxWidth = $clog2(MissTrkDepth),
   localparam int PqIdxWidth  = $clog2(PendQDepth),
   localparam int AddrWidth   = missProcPkg::AddrWidth,
   localparam int TlbIdWidth  = missProcPkg::TlbIdWidth
) (
   input  wire logic                    clk,
   input  wire logic                    reset_i,
   // From CAM return stage
   input  wire logic                    retVld_i,
   input  missProcPkg::opcode_e         retOpcode_i,
   input  wire logic [AddrWidth-1:0]    retAddr_i,
   input  wire logic [TlbIdWidth-1:0]   retTlbId_i,
   input  wire logic                    retHitVld_i,
   input  wire logic [TrkIdxWidth-1:0]  retHitIdx_i,
   // Queue status
   input  wire logic                    pendQFull_i,
   input  wire logic [MissTrkDepth-1:0] trkVacant_i,
   input  wire logic [PendQDepth-1:0]   pendQVacant_i,
   // Out stage state back to lookup
   output logic                         outVld_o,
   output missProcPkg::opcode_e         outOpcode_o,
   output logic      [AddrWidth-1:0]    outAddr_o,
   output logic      [TlbIdWidth-1:0]   outTlbId_o,
   output logic                         outTrkPut_o,
   output logic      [TrkIdxWidth-1:0]  outTrkIdx_o,
   output logic      [TrkIdxWidth-1:0]  outHitIdx_o,
   output logic                         outHitVld_o,
   // Puts and credits
   output logic                         trkPut_o,
   output logic      [TrkIdxWidth-1:0]  trkIdx_o,
   output logic                         pendQPut_o,
   output logic      [PqIdxWidth-1:0]   pendQIdx_o,
   output logic      [TrkIdxWidth-1:0]  pendQMsHitIdx_o,
   output logic                         primCrdRet_o,
   output logic                         pendQCrdRet_o
);

   logic                    outVld;
   logic                    outHitVld;
   logic [TrkIdxWidth-1:0]  outHitIdx;
   logic                    toTrk;
   logic                    toPendQ;
   logic [TrkIdxWidth-1:0]  trkGntIdx;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         outVld    <= 1'b0;
         outHitVld <= 1'b0;
      end else begin
         outVld    <= retVld_i;
         outHitVld <= retVld_i && retHitVld_i;
      end
   end

   always_ff @(posedge clk) begin
      outOpcode_o <= retOpcode_i;
      outAddr_o   <= retAddr_i;
      outTlbId_o  <= retTlbId_i;
      outHitIdx   <= retHitIdx_i;
   end

   //--------------------------------------------------
   // Routing, full pending queue falls back to tracker
   //--------------------------------------------------
   assign toPendQ = outVld && outHitVld && !pendQFull_i;
   assign toTrk   = outVld && !(outHitVld && !pendQFull_i);

   vacancyClaim #(.Depth(MissTrkDepth)) trkClaim (
      .clk      (clk),
      .reset_i  (reset_i),
      .vacant_i (trkVacant_i),
      .claim_i  (toTrk),
      .idx_o    (trkGntIdx)
   );

   vacancyClaim #(.Depth(PendQDepth)) pendQClaim (
      .clk      (clk),
      .reset_i  (reset_i),
      .vacant_i (pendQVacant_i),
      .claim_i  (toPendQ),
      .idx_o    (pendQIdx_o)
   );

   assign trkPut_o        = toTrk;
   assign trkIdx_o        = trkGntIdx;
   assign pendQPut_o      = toPendQ;
   assign pendQMsHitIdx_o = outHitIdx;

   // Parked miss frees a primary credit, new entry frees a pending one
   assign primCrdRet_o  = toPendQ;
   assign pendQCrdRet_o = toTrk;

   assign outVld_o    = outVld;
   assign outTrkPut_o = toTrk;
   assign outTrkIdx_o = trkGntIdx;
   assign outHitIdx_o = outHitIdx;
   assign outHitVld_o = outHitVld;

endmodule

`default_nettype wire

//--- verilog/vacancyClaim.sv
// Round-robin vacancy claim
// Picks the first vacant entry at or after a rotating pointer

`timescale 1ns/10ps
`default_nettype none

module vacancyClaim #(
   parameter int Depth = 8,
   localparam int IdxWidth = $clog2(Depth)
) (
   input  wire logic                clk,
   input  wire logic                reset_i,
   input  wire logic [Depth-1:0]    vacant_i,
   input  wire logic                claim_i,
   output logic      [IdxWidth-1:0] idx_o
);

   logic [IdxWidth-1:0] ptr;                        // Search start
   logic                found;

   //--------------------------------------------------
   // Cyclic first-vacant search
   //--------------------------------------------------
   always_comb begin
      int cand;

      found = 1'b0;
      idx_o = '0;                                   // Nothing vacant, index 0
      for (int i = 0; i < Depth; i++) begin
         cand = (int'(ptr) + i) % Depth;
         if (!found && vacant_i[cand]) begin
            found = 1'b1;
            idx_o = IdxWidth'(cand);
         end
      end
   end

   // Pointer moves past the granted entry
   always_ff @(posedge clk) begin
      if (reset_i) begin
         ptr <= '0;
      end else if (claim_i) begin
         if (int'(idx_o) == Depth - 1) begin
            ptr <= '0;
         end else begin
            ptr <= idx_o + IdxWidth'(1);
         end
      end
   end

endmodule

`default_nettype wire
